/* src/adc_pkg.sv */
package adc_pkg;

    localparam int FRAME_W = 16;    // spi frame width.
    localparam int CHAN_W  = 2;
    localparam int N_CHIPS = 4;

    // cache_cmd field positions.
    localparam int FREQ_LSB     = 20;
    localparam int FREQ_W       = 3;
    localparam int FILT_UP_LSB  = 16;
    localparam int FILT_LOW_LSB = 12;
    localparam int FILT_W       = 4;

    // opcode sits in bits 15:14 of each command frame.
    typedef enum logic [1:0] {
        OP_INIT = 2'd0,
        OP_TYPE = 2'd1,
        OP_CONF = 2'd2,
        OP_CONV = 2'd3
    } adc_op_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LOAD  = 2'd1,
        SHIFT = 2'd2,
        POST  = 2'd3
    } ctrl_state_e;

    typedef struct packed {
        logic [CHAN_W-1:0]  chan;
        logic [FRAME_W-1:0] data;
    } sample_t;

endpackage

/* src/sample_bus_if.sv */
`timescale 1ns/1ps

interface sample_bus_if;
    import adc_pkg::*;

    logic    req;
    sample_t sample;
    logic    grant;
    logic    overrun_clr;    // pulses when init starts.

    modport controller (
        output req, sample, overrun_clr,
        input  grant
    );

    modport arbiter (
        input  req, sample, overrun_clr,
        output grant
    );

endinterface

/* src/intan_spi.sv */
`timescale 1ns/1ps

module intan_spi #(
    parameter int SCLK_DIV = 2
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic [adc_pkg::FRAME_W-1:0] tx_word,
    output logic [adc_pkg::FRAME_W-1:0] rx_word,
    output logic                        done,
    input  logic                        miso,
    output logic                        mosi,
    output logic                        sclk,
    output logic                        cs
);
    import adc_pkg::*;

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(FRAME_W);

    logic [FRAME_W-1:0] tx_sh;
    logic [FRAME_W-1:0] rx_sh;
    logic [DIV_W-1:0]   div_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    logic               busy;
    logic               last;     // last rising edge seen.
    logic               tick;
    logic               rise;
    logic               fall;

    assign tick    = busy && !last && (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign rise    = tick && !sclk;
    assign fall    = tick && sclk;
    assign rx_word = rx_sh;    // stable between frames.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs      <= 1'b1;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            busy    <= 1'b0;
            last    <= 1'b0;
            done    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    cs      <= 1'b0;
                    mosi    <= tx_word[FRAME_W-1];    // first bit valid before first rise.
                    busy    <= 1'b1;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (last) begin
                sclk <= 1'b0;
                cs   <= 1'b1;
                mosi <= 1'b0;
                busy <= 1'b0;
                last <= 1'b0;
                done <= 1'b1;
            end else if (tick) begin
                div_cnt <= '0;
                sclk    <= ~sclk;
                if (rise) begin
                    last <= (bit_cnt == BIT_W'(FRAME_W - 1));
                end else begin
                    mosi    <= tx_sh[FRAME_W-1];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            tx_sh <= {tx_word[FRAME_W-2:0], 1'b0};
        end else if (fall) begin
            tx_sh <= {tx_sh[FRAME_W-2:0], 1'b0};
        end
        if (rise) begin
            rx_sh <= {rx_sh[FRAME_W-2:0], miso};    // msb first.
        end
    end

endmodule

/* src/intan_ctrl.sv */
`timescale 1ns/1ps

module intan_ctrl #(
    parameter int SCLK_DIV = 2,
    parameter int CHAN     = 0
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fs_init,
    input  logic                        fs_type,
    input  logic                        fs_conf,
    input  logic                        fs_conv,
    input  logic [adc_pkg::FREQ_W-1:0]  freq_samp,
    input  logic [adc_pkg::FILT_W-1:0]  filt_up,
    input  logic [adc_pkg::FILT_W-1:0]  filt_low,
    output logic                        fd_init,
    output logic                        fd_type,
    output logic                        fd_conf,
    output logic                        fd_conv,
    output logic [1:0]                  device_type,
    output logic [adc_pkg::FRAME_W-1:0] device_temp,
    output logic                        stat,
    input  logic                        miso,
    output logic                        mosi,
    output logic                        sclk,
    output logic                        cs,
    sample_bus_if.controller            bus
);
    import adc_pkg::*;

    ctrl_state_e        state;
    adc_op_e            op;
    logic               second;    // temperature frame of a type read.
    logic               accept;
    logic               spi_done;
    logic [FRAME_W-1:0] tx_word;
    logic [FRAME_W-1:0] rx_word;

    assign accept = (state == IDLE) && (fs_init || fs_type || fs_conf || fs_conv);
    assign bus.overrun_clr = accept && fs_init;

    assign tx_word = (op == OP_CONF) ? {op, 3'b000, freq_samp, filt_up, filt_low}
                                     : {op, {(FRAME_W - 2){1'b0}}};

    intan_spi #(
        .SCLK_DIV (SCLK_DIV)
    ) u_spi (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (state == LOAD),
        .tx_word (tx_word),
        .rx_word (rx_word),
        .done    (spi_done),
        .miso    (miso),
        .mosi    (mosi),
        .sclk    (sclk),
        .cs      (cs)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            op          <= OP_INIT;
            second      <= 1'b0;
            fd_init     <= 1'b0;
            fd_type     <= 1'b0;
            fd_conf     <= 1'b0;
            fd_conv     <= 1'b0;
            device_type <= '0;
            device_temp <= '0;
            stat        <= 1'b0;
            bus.req     <= 1'b0;
        end else begin
            if (bus.grant) bus.req <= 1'b0;    // taken by the arbiter.
            case (state)
                IDLE: if (accept) begin
                    state  <= LOAD;
                    second <= 1'b0;
                    if (fs_init) begin
                        op      <= OP_INIT;
                        fd_init <= 1'b0;
                        stat    <= 1'b0;
                    end else if (fs_type) begin
                        op      <= OP_TYPE;
                        fd_type <= 1'b0;
                    end else if (fs_conf) begin
                        op      <= OP_CONF;
                        fd_conf <= 1'b0;
                    end else begin
                        op      <= OP_CONV;
                        fd_conv <= 1'b0;
                    end
                end
                LOAD:  state <= SHIFT;
                SHIFT: if (spi_done) state <= POST;
                POST: begin
                    state <= IDLE;
                    case (op)
                        OP_INIT: fd_init <= 1'b1;
                        OP_TYPE: if (!second) begin
                            device_type <= rx_word[1:0];
                            second      <= 1'b1;
                            state       <= LOAD;    // same opcode again for temperature.
                        end else begin
                            device_temp <= rx_word;
                            fd_type     <= 1'b1;
                        end
                        OP_CONF: fd_conf <= 1'b1;
                        OP_CONV: begin
                            fd_conv <= 1'b1;
                            bus.req <= 1'b1;
                            // previous sample never granted and now lost.
                            if (bus.req && !bus.grant) stat <= 1'b1;
                        end
                    endcase
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == POST && op == OP_CONV) begin
            bus.sample <= '{chan: CHAN_W'(CHAN), data: rx_word};
        end
    end

endmodule

/* src/sample_arbiter.sv */
`timescale 1ns/1ps

module sample_arbiter #(
    parameter int CREDITS = 4
) (
    input  logic                        clk,
    input  logic                        arst_n,
    sample_bus_if.arbiter               bus0,
    sample_bus_if.arbiter               bus1,
    sample_bus_if.arbiter               bus2,
    sample_bus_if.arbiter               bus3,
    output logic                        sample_valid,
    output logic [adc_pkg::CHAN_W-1:0]  sample_chan,
    output logic [adc_pkg::FRAME_W-1:0] sample_data,
    input  logic                        credit_ret
);
    import adc_pkg::*;

    localparam int CRD_W = $clog2(CREDITS + 1);

    logic [N_CHIPS-1:0] req;
    logic [N_CHIPS-1:0] clr;
    logic [N_CHIPS-1:0] gnt;
    sample_t            smp [N_CHIPS];
    logic [CHAN_W-1:0]  last_q;    // last chip served.
    logic [CHAN_W-1:0]  cand;
    logic [CHAN_W-1:0]  gnt_idx;
    logic [CRD_W-1:0]   credits;

    assign req = {bus3.req, bus2.req, bus1.req, bus0.req};
    assign clr = {bus3.overrun_clr, bus2.overrun_clr, bus1.overrun_clr, bus0.overrun_clr};
    assign smp[0] = bus0.sample;
    assign smp[1] = bus1.sample;
    assign smp[2] = bus2.sample;
    assign smp[3] = bus3.sample;

    assign bus0.grant = gnt[0];
    assign bus1.grant = gnt[1];
    assign bus2.grant = gnt[2];
    assign bus3.grant = gnt[3];

    // first requester after last_q with wraparound.
    always_comb begin
        gnt     = '0;
        gnt_idx = last_q;
        cand    = last_q;
        if (credits != '0) begin
            for (int i = 1; i <= N_CHIPS; i++) begin
                cand = last_q + CHAN_W'(i);
                if (req[cand] && gnt == '0) begin
                    gnt[cand] = 1'b1;
                    gnt_idx   = cand;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q       <= CHAN_W'(N_CHIPS - 1);    // chip 0 goes first.
            credits      <= CRD_W'(CREDITS);
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= |gnt;
            if (&clr) begin
                last_q <= CHAN_W'(N_CHIPS - 1);
            end else if (|gnt) begin
                last_q <= gnt_idx;
            end
            // a credit is spent at grant one cycle ahead of sample_valid.
            case ({|gnt, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (|gnt) begin
            sample_chan <= smp[gnt_idx].chan;
            sample_data <= smp[gnt_idx].data;
        end
    end

endmodule

/* src/adc.sv */
`timescale 1ns/1ps

module adc #(
    parameter int SCLK_DIV = 2,
    parameter int CREDITS  = 4
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fs_init,
    input  logic                        fs_type,
    input  logic                        fs_conf,
    input  logic                        fs_conv,
    output logic                        fd_init,
    output logic                        fd_type,
    output logic                        fd_conf,
    output logic                        fd_conv,
    input  logic [31:0]                 cache_cmd,
    output logic [31:0]                 cache_stat,
    input  logic [3:0]                  pin_miso,
    output logic [3:0]                  pin_mosi,
    output logic [3:0]                  pin_sclk,
    output logic [3:0]                  pin_cs,
    output logic                        sample_valid,
    output logic [adc_pkg::CHAN_W-1:0]  sample_chan,
    output logic [adc_pkg::FRAME_W-1:0] sample_data,
    input  logic                        credit_ret
);
    import adc_pkg::*;

    logic [N_CHIPS-1:0]   fdc_init;
    logic [N_CHIPS-1:0]   fdc_type;
    logic [N_CHIPS-1:0]   fdc_conf;
    logic [N_CHIPS-1:0]   fdc_conv;
    logic [N_CHIPS-1:0]   device_stat;    // sticky overrun per chip.
    logic [2*N_CHIPS-1:0] device_type;
    logic [FRAME_W-1:0]   temp [N_CHIPS];
    logic [FRAME_W+1:0]   temp_sum;
    logic [FREQ_W-1:0]    freq_samp;
    logic [FILT_W-1:0]    filt_up;
    logic [FILT_W-1:0]    filt_low;

    sample_bus_if sbus [N_CHIPS] ();

    assign fd_init = &fdc_init;
    assign fd_type = &fdc_type;
    assign fd_conf = &fdc_conf;
    assign fd_conv = &fdc_conv;

    assign temp_sum = 18'(temp[0]) + 18'(temp[1]) + 18'(temp[2]) + 18'(temp[3]);
    assign cache_stat = {temp_sum[FRAME_W+1:2], device_type, device_stat, 4'h0};

    assign freq_samp = cache_cmd[FREQ_LSB +: FREQ_W];
    assign filt_up   = cache_cmd[FILT_UP_LSB +: FILT_W];
    assign filt_low  = cache_cmd[FILT_LOW_LSB +: FILT_W];

    for (genvar k = N_CHIPS - 1; k >= 0; k--) begin : g_chip
        intan_ctrl #(
            .SCLK_DIV (SCLK_DIV),
            .CHAN     (k)
        ) u_ctrl (
            .clk         (clk),
            .arst_n      (arst_n),
            .fs_init     (fs_init),
            .fs_type     (fs_type),
            .fs_conf     (fs_conf),
            .fs_conv     (fs_conv),
            .freq_samp   (freq_samp),
            .filt_up     (filt_up),
            .filt_low    (filt_low),
            .fd_init     (fdc_init[k]),
            .fd_type     (fdc_type[k]),
            .fd_conf     (fdc_conf[k]),
            .fd_conv     (fdc_conv[k]),
            .device_type (device_type[2*k +: 2]),
            .device_temp (temp[k]),
            .stat        (device_stat[k]),
            .miso        (pin_miso[k]),
            .mosi        (pin_mosi[k]),
            .sclk        (pin_sclk[k]),
            .cs          (pin_cs[k]),
            .bus         (sbus[k])
        );
    end

    sample_arbiter #(
        .CREDITS (CREDITS)
    ) u_arb (
        .clk          (clk),
        .arst_n       (arst_n),
        .bus0         (sbus[0]),
        .bus1         (sbus[1]),
        .bus2         (sbus[2]),
        .bus3         (sbus[3]),
        .sample_valid (sample_valid),
        .sample_chan  (sample_chan),
        .sample_data  (sample_data),
        .credit_ret   (credit_ret)
    );

endmodule

/* test/intan_model.sv */
`timescale 1ns/1ps

module intan_model #(
    parameter int          K    = 0,
    parameter logic [15:0] TEMP = 16'h0000
) (
    input  logic        sclk,
    input  logic        cs,
    input  logic        mosi,
    output logic        miso,
    output logic [10:0] cfg
);
    logic [15:0] cmd;          // command bits in msb first order.
    logic [13:0] count;
    logic        temp_next;    // next type frame returns the temperature.
    logic [15:0] type_word;
    logic [15:0] conv_word;
    logic        op1;
    logic        op0;
    int          nbit;
    int          pos;

    assign type_word = {14'b0, 2'(K + 1)};
    assign conv_word = {2'(K), count};

    initial begin
        cmd       = '0;
        count     = '0;
        temp_next = 1'b0;
        cfg       = '0;
        nbit      = 0;
    end

    // each reply bit is picked from what the frame has shown so far.
    always_comb begin
        op1  = (nbit == 0) ? mosi : cmd[15];
        op0  = (nbit <= 1) ? mosi : cmd[14];
        pos  = 15 - nbit;
        miso = 1'b0;
        if (nbit == 0) begin
            // opcode bit 14 not seen yet and conf replies go unused.
            miso = op1 ? conv_word[15] : (temp_next & TEMP[15]);
        end else if (nbit < 16) begin
            case ({op1, op0})
                2'b01:   miso = temp_next ? TEMP[pos] : type_word[pos];
                2'b10:   miso = (pos <= 10) ? mosi : 1'b0;    // echo of the config bits.
                2'b11:   miso = conv_word[pos];
                default: miso = 1'b0;
            endcase
        end
    end

    always @(posedge sclk) begin
        if (!cs && nbit < 16) begin
            cmd[15 - nbit] <= mosi;
            nbit           <= nbit + 1;
        end
    end

    always @(posedge cs) begin
        nbit <= 0;
        case (cmd[15:14])
            2'b00: begin
                count     <= '0;
                temp_next <= 1'b0;
            end
            2'b01: temp_next <= !temp_next;
            2'b10: begin
                cfg       <= cmd[10:0];
                temp_next <= 1'b0;
            end
            default: begin
                count     <= count + 1'b1;
                temp_next <= 1'b0;
            end
        endcase
    end

endmodule

/* test/tb_adc.sv */
`timescale 1ns/1ps

module tb_adc;
    import adc_pkg::*;

    localparam int CREDITS = 4;
    localparam int TIMEOUT = 2000;
    localparam int N_ENT   = 13;

    typedef struct packed {
        adc_op_e     op;
        logic [31:0] cmd;
        logic        hold;    // consumer keeps its credits.
        logic        drop;    // this sample is replaced before it is granted.
        logic [3:0]  ovr;
    } entry_t;

    logic                clk;
    logic                arst_n;
    logic                fs_init;
    logic                fs_type;
    logic                fs_conf;
    logic                fs_conv;
    logic                fd_init;
    logic                fd_type;
    logic                fd_conf;
    logic                fd_conv;
    logic [31:0]         cache_cmd;
    logic [31:0]         cache_stat;
    logic [3:0]          pin_miso;
    logic [3:0]          pin_mosi;
    logic [3:0]          pin_sclk;
    logic [3:0]          pin_cs;
    logic                sample_valid;
    logic [CHAN_W-1:0]   sample_chan;
    logic [FRAME_W-1:0]  sample_data;
    logic                credit_ret;
    logic [4*11-1:0]     model_cfg;

    entry_t      tbl [N_ENT];
    sample_t     exp_q [$];
    int          due_q [$];
    int          cnt [N_CHIPS];
    logic        hold = 1'b0;
    logic        typed = 1'b0;
    int          n_smp = 0;
    int          n_ret = 0;
    int          cyc = 0;
    int          mismatches = 0;
    int          timeouts = 0;
    int          faults = 0;
    logic [31:0] rng = 32'he5cf_1573;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] temp_of(input int k);
        return 16'h1000 + 16'(k) * 16'h0344;    // sum stays a multiple of 4.
    endfunction

    function automatic logic [31:0] expected_stat(input logic [3:0] ovr, input logic have_type);
        logic [17:0] sum;
        logic [7:0]  types;
        sum   = '0;
        types = '0;
        for (int k = 0; k < N_CHIPS; k++) begin
            sum              = sum + 18'(temp_of(k));
            types[2*k +: 2] = 2'(k + 1);    // type wraps modulo 4.
        end
        if (!have_type) begin
            sum   = '0;
            types = '0;
        end
        return {sum[17:2], types, ovr, 4'h0};
    endfunction

    function automatic logic fd_level(input adc_op_e op);
        case (op)
            OP_INIT: return fd_init;
            OP_TYPE: return fd_type;
            OP_CONF: return fd_conf;
            default: return fd_conv;
        endcase
    endfunction

    task automatic check_stat(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_cfg(input string name, input logic [10:0] exp, input logic [10:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic fire_strobe(input adc_op_e op, input logic [31:0] cmd);
        @(posedge clk);
        #1;
        cache_cmd = cmd;
        fs_init   = (op == OP_INIT);
        fs_type   = (op == OP_TYPE);
        fs_conf   = (op == OP_CONF);
        fs_conv   = (op == OP_CONV);
        @(posedge clk);
        #1;
        fs_init = 1'b0;
        fs_type = 1'b0;
        fs_conf = 1'b0;
        fs_conv = 1'b0;
    endtask

    task automatic wait_done(input adc_op_e op);
        int   n;
        logic d;
        n = 0;
        d = 1'b0;
        while (!d && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            d = fd_level(op);
        end
        if (!d) begin
            timeouts++;
            $display("Timeout: done level of %s never rose", op.name());
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || n_smp != n_ret) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0 || n_smp != n_ret) begin
            timeouts++;
            $display("Timeout: %0d samples never arrived, %0d credits not returned",
                     exp_q.size(), n_smp - n_ret);
        end
    endtask

    adc #(
        .SCLK_DIV (2),
        .CREDITS  (CREDITS)
    ) u_adc (
        .clk          (clk),
        .arst_n       (arst_n),
        .fs_init      (fs_init),
        .fs_type      (fs_type),
        .fs_conf      (fs_conf),
        .fs_conv      (fs_conv),
        .fd_init      (fd_init),
        .fd_type      (fd_type),
        .fd_conf      (fd_conf),
        .fd_conv      (fd_conv),
        .cache_cmd    (cache_cmd),
        .cache_stat   (cache_stat),
        .pin_miso     (pin_miso),
        .pin_mosi     (pin_mosi),
        .pin_sclk     (pin_sclk),
        .pin_cs       (pin_cs),
        .sample_valid (sample_valid),
        .sample_chan  (sample_chan),
        .sample_data  (sample_data),
        .credit_ret   (credit_ret)
    );

    for (genvar k = 0; k < N_CHIPS; k++) begin : g_model
        intan_model #(
            .K    (k),
            .TEMP (temp_of(k))
        ) u_model (
            .sclk (pin_sclk[k]),
            .cs   (pin_cs[k]),
            .mosi (pin_mosi[k]),
            .miso (pin_miso[k]),
            .cfg  (model_cfg[11*k +: 11])
        );
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin : monitor
        sample_t act;
        sample_t e;
        int      idx;
        if (sample_valid === 1'b1) begin
            act = {sample_chan, sample_data};
            n_smp++;
            rng = xorshift(rng);
            due_q.push_back(cyc + 1 + int'(rng % 6));
            idx = -1;
            for (int i = 0; i < exp_q.size(); i++) begin
                e = exp_q[i];
                if (idx < 0 && e.chan == act.chan) idx = i;
            end
            if (idx < 0) begin
                faults++;
                $display("Unexpected sample from chip %0d", act.chan);
            end else begin
                check_sample($sformatf("sample chip %0d", act.chan), exp_q[idx], act);
                exp_q.delete(idx);
            end
        end
        if (n_smp - n_ret > CREDITS) begin
            faults++;
            $display("More than %0d samples issued without a returned credit", CREDITS);
        end
    end

    always @(posedge clk) begin : consumer
        int junk;
        if (credit_ret === 1'b1) n_ret++;    // the DUT takes this credit at this edge.
        cyc++;
        #1;
        credit_ret = 1'b0;
        if (!hold && due_q.size() > 0) begin
            if (due_q[0] <= cyc) begin
                junk       = due_q.pop_front();
                credit_ret = 1'b1;
            end
        end
    end

    initial begin : run
        entry_t  cur;
        adc_op_e op;
        string   name;
        arst_n     = 1'b0;
        fs_init    = 1'b0;
        fs_type    = 1'b0;
        fs_conf    = 1'b0;
        fs_conv    = 1'b0;
        cache_cmd  = '0;
        credit_ret = 1'b0;
        for (int k = 0; k < N_CHIPS; k++) cnt[k] = 0;

        tbl[0]  = {OP_INIT, 32'h0000_0000, 1'b0, 1'b0, 4'h0};
        tbl[1]  = {OP_TYPE, 32'h0000_0000, 1'b0, 1'b0, 4'h0};
        tbl[2]  = {OP_CONF, 32'h0059_6000, 1'b0, 1'b0, 4'h0};
        tbl[3]  = {OP_CONF, 32'hA12C_3F0F, 1'b0, 1'b0, 4'h0};    // junk outside the fields.
        tbl[4]  = {OP_CONV, 32'h0000_0000, 1'b0, 1'b0, 4'h0};
        tbl[5]  = {OP_CONV, 32'h0000_0000, 1'b0, 1'b0, 4'h0};
        tbl[6]  = {OP_CONV, 32'h0000_0000, 1'b0, 1'b0, 4'h0};
        tbl[7]  = {OP_CONV, 32'h0000_0000, 1'b1, 1'b0, 4'h0};    // uses up all credits.
        tbl[8]  = {OP_CONV, 32'h0000_0000, 1'b1, 1'b1, 4'h0};
        tbl[9]  = {OP_CONV, 32'h0000_0000, 1'b1, 1'b0, 4'hF};
        tbl[10] = {OP_INIT, 32'h0000_0000, 1'b0, 1'b0, 4'h0};
        tbl[11] = {OP_CONV, 32'h0000_0000, 1'b0, 1'b0, 4'h0};
        tbl[12] = {OP_CONV, 32'h0000_0000, 1'b0, 1'b0, 4'h0};

        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_done("fd_init after reset", 1'b0, fd_init);
        check_done("fd_type after reset", 1'b0, fd_type);
        check_done("fd_conf after reset", 1'b0, fd_conf);
        check_done("fd_conv after reset", 1'b0, fd_conv);
        check_done("sample_valid after reset", 1'b0, sample_valid);
        for (int k = 0; k < N_CHIPS; k++) begin
            check_done($sformatf("pin_cs[%0d] after reset", k), 1'b1, pin_cs[k]);
            check_done($sformatf("pin_sclk[%0d] after reset", k), 1'b0, pin_sclk[k]);
            check_done($sformatf("pin_mosi[%0d] after reset", k), 1'b0, pin_mosi[k]);
        end
        check_stat("cache_stat after reset", 32'h0, cache_stat);

        for (int i = 0; i < N_ENT; i++) begin
            cur  = tbl[i];
            op   = cur.op;
            name = $sformatf("entry %0d %s", i, op.name());
            hold = cur.hold;
            if (op == OP_INIT) begin
                for (int k = 0; k < N_CHIPS; k++) cnt[k] = 0;
            end else if (op == OP_CONV) begin
                for (int k = 0; k < N_CHIPS; k++) begin
                    if (!cur.drop) exp_q.push_back({2'(k), 2'(k), 14'(cnt[k])});
                    cnt[k]++;
                end
            end
            fire_strobe(op, cur.cmd);
            wait_done(op);
            if (!cur.hold) wait_drain();
            if (op == OP_TYPE) typed = 1'b1;
            check_stat(name, expected_stat(cur.ovr, typed), cache_stat);
            if (op == OP_CONF) begin
                for (int k = 0; k < N_CHIPS; k++) begin
                    check_cfg($sformatf("%s model %0d", name, k),
                              {cur.cmd[FREQ_LSB +: FREQ_W], cur.cmd[FILT_UP_LSB +: FILT_W],
                               cur.cmd[FILT_LOW_LSB +: FILT_W]},
                              model_cfg[11*k +: 11]);
                end
            end
        end
        hold = 1'b0;
        wait_drain();

        $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts, faults);
        if (mismatches + timeouts + faults == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
src/adc_pkg.sv
src/sample_bus_if.sv
src/intan_spi.sv
src/intan_ctrl.sv
src/sample_arbiter.sv
src/adc.sv
test/intan_model.sv
test/tb_adc.sv
